// File: tests/input_tests.txt
# one step per line: enable v, uart v, sw hex, glitch hex cycles, idle cycles, keys chars scans
# check name data(dec) complete(seen since last check) pause switch_enable state(0 blk 1 sw 2 kp 3 halt)
check after_reset 0 0 0 0 0
enable 1
keys 407# 5
wait_complete 400
check decimal_entry 407 1 0 0 2
keys 12 5
check two_digits 12 0 0 0 2
keys *** 5
check backspace 0 0 0 0 2
keys 123456789# 5
wait_complete 2000
check nine_digits 12345678 1 0 0 2
keys B 5
check toggle 0 0 0 1 1
sw a5c3
wait_data 42435 200
check switch_value 42435 0 0 1 1
glitch 00ff 10
idle 40
check switch_glitch 42435 0 0 1 1
keys # 5
wait_complete 400
check switch_enter 42435 1 0 0 2
keys 58 5
enable 0
idle 4
check enable_drop 58 0 0 0 0
enable 1
keys 3 5
keys 6 2
check short_press 3 0 0 0 2
keys 9 12
check long_press 39 0 0 0 2
keys A 5
wait_pause 200
check pause 39 1 1 0 3
keys A 5
check pause_held 39 1 1 0 3
enable 0
uart 1
keys A 5
check resume 39 1 0 0 0

// File: src.f
common/input_pkg.sv
keypad/keypad_scanner.sv
logic/switch_filter.sv
input_ctrl/input_unit.sv
logic/user_input_top.sv
tests/input_checker.sv
tests/tb_user_input.sv

// File: Makefile
# Verilator build and run for the user input front end

VERILATOR ?= verilator
TOP       ?= tb_user_input
FILELIST  ?= src.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx 'Result: PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_user_input.sv
`timescale 1ns/1ps
`default_nettype none

module tb_user_input;
    import input_pkg::*;

    localparam int DATA_WIDTH     = 32;
    localparam int SWITCH_CNT     = 16;
    localparam int SCAN_DIV       = 4;
    localparam int DEBOUNCE_SCANS = 3;
    localparam int FILTER_CYCLES  = 20;
    localparam int SCAN_CYCLES    = 4 * SCAN_DIV;  // one pass over all four rows

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [3:0]            key_row;
    logic [3:0]            key_col;
    logic [SWITCH_CNT-1:0] switch_raw;
    logic                  input_enable;
    logic                  uart_complete;
    logic [DATA_WIDTH-1:0] input_data;
    logic                  input_complete;
    logic                  switch_enable;
    logic                  cpu_pause;
    input_state_t          input_state;

    logic                  key_down;
    logic [1:0]            press_row;
    logic [1:0]            press_col;

    logic                  strobe;
    logic [8*24-1:0]       test_name;
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_complete;
    logic                  exp_pause;
    logic                  exp_switch;
    logic [1:0]            exp_state;
    logic                  watch;  // switch glitch in progress
    int                    pass_cnt;
    int                    fail_cnt;

    logic                  complete_q = 1'b0;
    int                    rise_cnt = 0;  // rising edges of input_complete
    int                    rise_mark;
    int                    fd;
    int                    got;
    logic [8*16-1:0]       cmd;
    logic                  run_broken;

    always #5 clk = ~clk;

    // a held key shorts its row line to its column line
    always_comb begin
        key_col = 4'hF;
        if (key_down && !key_row[press_row]) begin
            key_col[press_col] = 1'b0;
        end
    end

    always @(posedge clk) begin
        complete_q <= input_complete;
        if (input_complete && !complete_q) begin
            rise_cnt <= rise_cnt + 1;
        end
    end

    user_input_top #(
        .DATA_WIDTH     (DATA_WIDTH),
        .SWITCH_CNT     (SWITCH_CNT),
        .SCAN_DIV       (SCAN_DIV),
        .DEBOUNCE_SCANS (DEBOUNCE_SCANS),
        .FILTER_CYCLES  (FILTER_CYCLES)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_col        (key_col),
        .switch_raw     (switch_raw),
        .input_enable   (input_enable),
        .uart_complete  (uart_complete),
        .key_row        (key_row),
        .input_data     (input_data),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .input_state    (input_state)
    );

    input_checker #(
        .DATA_WIDTH (DATA_WIDTH)
    ) checker_i (
        .clk            (clk),
        .strobe         (strobe),
        .test_name      (test_name),
        .exp_data       (exp_data),
        .exp_complete   (exp_complete),
        .exp_pause      (exp_pause),
        .exp_switch     (exp_switch),
        .exp_state      (exp_state),
        .watch          (watch),
        .key_row        (key_row),
        .input_data     (input_data),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .input_state    (input_state),
        .pass_cnt       (pass_cnt),
        .fail_cnt       (fail_cnt)
    );

    // row major position on the keypad face or -1 for a character not on it
    function automatic int key_index(input logic [7:0] ch);
        logic [8*16-1:0] layout;
        int              idx;
        layout = "123A456B789C*0#D";
        idx    = -1;
        for (int i = 0; i < 16; i++) begin
            if (layout[(15 - i) * 8 +: 8] == ch) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic press_key(input logic [7:0] ch, input int scans);
        int idx;
        idx = key_index(ch);
        if (idx < 0) begin
            $display("Unknown key '%c' in the test file", ch);
            run_broken = 1'b1;
        end else begin
            @(negedge clk);
            press_row = 2'(idx / 4);
            press_col = 2'(idx % 4);
            key_down  = 1'b1;
            repeat (scans * SCAN_CYCLES) @(negedge clk);
            key_down = 1'b0;
            repeat (2 * SCAN_CYCLES) @(negedge clk);  // released scans unlock the scanner
        end
    endtask

    task automatic type_keys(input logic [8*16-1:0] text, input int scans);
        for (int i = 15; i >= 0; i--) begin
            if ((text[i*8 +: 8] != 8'h00) && !run_broken) begin
                press_key(text[i*8 +: 8], scans);
            end
        end
    endtask

    task automatic wait_for(input logic [8*16-1:0] what, input logic [31:0] value,
                            input int limit);
        int   n;
        logic met;
        n   = 0;
        met = 1'b0;
        while (!met && (n < limit)) begin
            @(negedge clk);
            n++;
            case (what)
                "wait_complete": met = (rise_cnt != rise_mark);
                "wait_pause":    met = cpu_pause;
                default:         met = (input_data == value);
            endcase
        end
        if (!met) begin
            $display("Timeout: %0s did not happen within %0d cycles", what, limit);
            run_broken = 1'b1;
        end
        if (what == "wait_complete") begin
            rise_mark = rise_cnt;
        end
    endtask

    task automatic check_step();
        logic [8*24-1:0] name;
        logic [31:0]     data;
        int              cmpl;
        int              pause;
        int              swen;
        int              state;
        int              n;
        n = $fscanf(fd, "%s %d %d %d %d %d", name, data, cmpl, pause, swen, state);
        if (n != 6) begin
            $display("Malformed check line in the test file");
            run_broken = 1'b1;
        end else begin
            @(negedge clk);
            test_name    = name;
            exp_data     = data;
            exp_complete = cmpl[0];
            exp_pause    = pause[0];
            exp_switch   = swen[0];
            exp_state    = state[1:0];
            strobe       = 1'b1;
            watch        = 1'b0;
            @(negedge clk);
            strobe = 1'b0;
        end
    endtask

    task automatic run_step();
        logic [8*120-1:0]      rest;
        logic [8*16-1:0]       text;
        logic [31:0]           val;
        logic [SWITCH_CNT-1:0] saved;
        int                    num;
        int                    n;
        case (cmd)
            "#": n = $fgets(rest, fd);
            "enable": begin
                n = $fscanf(fd, "%d", val);
                @(negedge clk);
                input_enable = val[0];
            end
            "uart": begin
                n = $fscanf(fd, "%d", val);
                @(negedge clk);
                uart_complete = val[0];
            end
            "sw": begin
                n = $fscanf(fd, "%h", val);
                @(negedge clk);
                switch_raw = val[SWITCH_CNT-1:0];
            end
            "glitch": begin
                n = $fscanf(fd, "%h %d", val, num);
                @(negedge clk);
                saved      = switch_raw;
                switch_raw = val[SWITCH_CNT-1:0];
                watch      = 1'b1;
                repeat (num) @(negedge clk);
                switch_raw = saved;  // bounce back to the settled value
            end
            "idle": begin
                n = $fscanf(fd, "%d", num);
                repeat (num) @(negedge clk);
            end
            "keys": begin
                n = $fscanf(fd, "%s %d", text, num);
                type_keys(text, num);
            end
            "wait_complete", "wait_pause": begin
                n = $fscanf(fd, "%d", num);
                wait_for(cmd, 32'd0, num);
            end
            "wait_data": begin
                n = $fscanf(fd, "%d %d", val, num);
                wait_for(cmd, val, num);
            end
            "check": check_step();
            default: begin
                $display("Unknown command in the test file: %0s", cmd);
                run_broken = 1'b1;
            end
        endcase
    endtask

    initial begin
        rst_n         = 1'b0;
        key_down      = 1'b0;
        press_row     = 2'd0;
        press_col     = 2'd0;
        switch_raw    = '0;
        input_enable  = 1'b0;
        uart_complete = 1'b0;
        strobe        = 1'b0;
        test_name     = '0;
        exp_data      = '0;
        exp_complete  = 1'b0;
        exp_pause     = 1'b0;
        exp_switch    = 1'b0;
        exp_state     = 2'd0;
        watch         = 1'b0;
        rise_mark     = 0;
        run_broken    = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("tests/input_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/input_tests.txt");
            run_broken = 1'b1;
        end
        got = 1;
        while ((got == 1) && !run_broken) begin
            cmd = '0;
            got = $fscanf(fd, "%s", cmd);
            if (got == 1) begin
                run_step();
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (4) @(negedge clk);
        $display("Totals: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (!run_broken && (fail_cnt == 0) && (pass_cnt > 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/input_checker.sv
`timescale 1ns/1ps
`default_nettype none

module input_checker #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    strobe,  // one comparison per pulse
    input  logic [8*24-1:0]         test_name,
    input  logic [DATA_WIDTH-1:0]   exp_data,
    input  logic                    exp_complete,
    input  logic                    exp_pause,
    input  logic                    exp_switch,
    input  logic [1:0]              exp_state,
    input  logic                    watch,   // input_data must hold while high
    input  logic [3:0]              key_row,
    input  logic [DATA_WIDTH-1:0]   input_data,
    input  logic                    input_complete,
    input  logic                    switch_enable,
    input  logic                    cpu_pause,
    input  input_pkg::input_state_t input_state,
    output int                      pass_cnt,
    output int                      fail_cnt
);

    logic                  cmpl_seen = 1'b0;  // input_complete high since the last check
    logic [DATA_WIDTH-1:0] cmpl_data = '0;    // input_data while input_complete was high
    logic [DATA_WIDTH-1:0] data_q = '0;
    logic                  moved = 1'b0;      // input_data changed inside a watch window
    logic [DATA_WIDTH-1:0] moved_data = '0;
    logic                  got_cmpl;
    logic [DATA_WIDTH-1:0] got_data;
    int                    errs = 0;
    int                    passed = 0;
    int                    failed = 0;

    assign pass_cnt = passed;
    assign fail_cnt = failed;

    task automatic compare_field(input string field, input logic [DATA_WIDTH-1:0] expected,
                                 input logic [DATA_WIDTH-1:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %0s: %0s expected %0d actual %0d",
                     test_name, field, expected, actual);
            errs++;
        end
    endtask

    always @(posedge clk) begin
        if (strobe) begin
            errs     = 0;
            got_cmpl = cmpl_seen || input_complete;
            if (moved) begin
                got_data = moved_data;  // value that leaked out during the watch
            end else if (exp_complete && !input_complete) begin
                got_data = cmpl_data;  // completion pulse already over
            end else begin
                got_data = input_data;
            end
            compare_field("input_data", exp_data, got_data);
            compare_field("input_complete", DATA_WIDTH'(exp_complete), DATA_WIDTH'(got_cmpl));
            compare_field("cpu_pause", DATA_WIDTH'(exp_pause), DATA_WIDTH'(cpu_pause));
            compare_field("switch_enable", DATA_WIDTH'(exp_switch), DATA_WIDTH'(switch_enable));
            compare_field("input_state", DATA_WIDTH'(exp_state), DATA_WIDTH'(input_state));
            if (!$onehot(~key_row)) begin
                $display("Row drive in %0s is not a single low row line: %b",
                         test_name, key_row);
                errs++;
            end
            if (errs == 0) begin
                $display("Pass %0s", test_name);
                passed++;
            end else begin
                failed++;
            end
            cmpl_seen <= 1'b0;
            moved     <= 1'b0;
        end
        if (input_complete) begin
            cmpl_seen <= 1'b1;
            cmpl_data <= input_data;
        end
        if (watch && !moved && (input_data != data_q)) begin
            moved      <= 1'b1;
            moved_data <= input_data;
        end
        data_q <= input_data;
    end

endmodule

`default_nettype wire

// File: logic/user_input_top.sv
`timescale 1ns/1ps
`default_nettype none

module user_input_top #(
    parameter int DATA_WIDTH     = 32,
    parameter int SWITCH_CNT     = 16,
    parameter int SCAN_DIV       = 50000,   // cycles per row slot
    parameter int DEBOUNCE_SCANS = 4,
    parameter int FILTER_CYCLES  = 100000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [3:0]              key_col,
    input  logic [SWITCH_CNT-1:0]   switch_raw,
    input  logic                    input_enable,
    input  logic                    uart_complete,
    output logic [3:0]              key_row,
    output logic [DATA_WIDTH-1:0]   input_data,
    output logic                    input_complete,
    output logic                    switch_enable,
    output logic                    cpu_pause,
    output input_pkg::input_state_t input_state
);
    import input_pkg::*;

    key_code_t             key_coord;   // one-cycle press report
    logic [SWITCH_CNT-1:0] switch_map;  // debounced switches

    keypad_scanner #(
        .SCAN_DIV       (SCAN_DIV),
        .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
    ) scanner_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_col   (key_col),
        .key_row   (key_row),
        .key_coord (key_coord)
    );

    switch_filter #(
        .SWITCH_CNT    (SWITCH_CNT),
        .FILTER_CYCLES (FILTER_CYCLES)
    ) filter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .switch_raw (switch_raw),
        .switch_map (switch_map)
    );

    input_unit #(
        .DATA_WIDTH (DATA_WIDTH),
        .SWITCH_CNT (SWITCH_CNT)
    ) unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_coord      (key_coord),
        .switch_map     (switch_map),
        .input_enable   (input_enable),
        .uart_complete  (uart_complete),
        .input_data     (input_data),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .input_state    (input_state)
    );

endmodule

`default_nettype wire

// File: input_ctrl/input_unit.sv
`timescale 1ns/1ps
`default_nettype none

module input_unit #(
    parameter int DATA_WIDTH = 32,
    parameter int SWITCH_CNT = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  input_pkg::key_code_t    key_coord,
    input  logic [SWITCH_CNT-1:0]   switch_map,
    input  logic                    input_enable,   // cpu asks for a value
    input  logic                    uart_complete,  // uart transfer finished
    output logic [DATA_WIDTH-1:0]   input_data,
    output logic                    input_complete,
    output logic                    switch_enable,
    output logic                    cpu_pause,
    output input_pkg::input_state_t input_state
);
    import input_pkg::*;

    localparam int CNT_W = $clog2(MAX_DIGITS + 1);

    logic [DATA_WIDTH-1:0] keypad_data;
    logic [CNT_W-1:0]      digit_cnt;
    logic                  digit_key;
    logic [3:0]            digit_val;

    always_comb begin
        digit_key = 1'b1;
        digit_val = 4'd0;
        case (key_coord)
            KEY_ZERO:  digit_val = 4'd0;
            KEY_ONE:   digit_val = 4'd1;
            KEY_TWO:   digit_val = 4'd2;
            KEY_THREE: digit_val = 4'd3;
            KEY_FOUR:  digit_val = 4'd4;
            KEY_FIVE:  digit_val = 4'd5;
            KEY_SIX:   digit_val = 4'd6;
            KEY_SEVEN: digit_val = 4'd7;
            KEY_EIGHT: digit_val = 4'd8;
            KEY_NINE:  digit_val = 4'd9;
            default:   digit_key = 1'b0;  // control keys and KEY_NONE
        endcase
    end

    assign input_data = switch_enable ? DATA_WIDTH'(switch_map) : keypad_data;

    // with input_enable still high, ST_BLOCK re-enters ST_KEYPAD on the next
    // cycle, so input_complete is a single-cycle pulse in that case
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_state    <= ST_BLOCK;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
            keypad_data    <= '0;
            digit_cnt      <= '0;
        end else begin
            case (input_state)
                ST_BLOCK: begin
                    if (key_coord == KEY_PAUSE) begin
                        input_state <= ST_HALT;
                        cpu_pause   <= 1'b1;
                    end else if (input_enable) begin
                        input_state    <= ST_KEYPAD;
                        input_complete <= 1'b0;
                        switch_enable  <= 1'b0;  // new entry starts on the keypad
                        keypad_data    <= '0;
                        digit_cnt      <= '0;
                    end
                end
                ST_KEYPAD: begin
                    if (!input_enable) begin
                        input_state <= ST_BLOCK;  // abandoned without completion
                    end else begin
                        case (key_coord)
                            KEY_TOGGLE: begin
                                input_state   <= ST_SWITCH;
                                switch_enable <= 1'b1;
                            end
                            KEY_BACKSPACE: begin
                                if (digit_cnt != '0) begin
                                    keypad_data <= keypad_data / DATA_WIDTH'(10);
                                    digit_cnt   <= digit_cnt - CNT_W'(1);
                                end
                            end
                            KEY_ENTER: begin
                                input_state    <= ST_BLOCK;
                                input_complete <= 1'b1;
                                digit_cnt      <= '0;
                            end
                            KEY_PAUSE: begin
                                input_state    <= ST_HALT;
                                input_complete <= 1'b1;
                                cpu_pause      <= 1'b1;
                                digit_cnt      <= '0;
                            end
                            default: begin
                                if (digit_key && (digit_cnt < CNT_W'(MAX_DIGITS))) begin
                                    keypad_data <= keypad_data * DATA_WIDTH'(10) +
                                                   DATA_WIDTH'(digit_val);
                                    digit_cnt   <= digit_cnt + CNT_W'(1);
                                end
                            end
                        endcase
                    end
                end
                ST_SWITCH: begin
                    case (key_coord)
                        KEY_TOGGLE: begin
                            input_state   <= ST_KEYPAD;  // back to keypad value
                            switch_enable <= 1'b0;
                        end
                        KEY_ENTER: begin
                            input_state    <= ST_BLOCK;
                            input_complete <= 1'b1;
                            digit_cnt      <= '0;
                        end
                        KEY_PAUSE: begin
                            input_state    <= ST_HALT;
                            input_complete <= 1'b1;
                            cpu_pause      <= 1'b1;
                            digit_cnt      <= '0;
                        end
                        default: ;
                    endcase
                end
                ST_HALT: begin
                    if (uart_complete && (key_coord == KEY_PAUSE)) begin
                        input_state <= ST_BLOCK;  // resume
                        cpu_pause   <= 1'b0;
                    end
                end
            endcase
        end
    end

    a_digit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        digit_cnt <= CNT_W'(MAX_DIGITS));

    a_pause_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_pause == (input_state == ST_HALT));

endmodule

`default_nettype wire

// File: logic/switch_filter.sv
`timescale 1ns/1ps
`default_nettype none

module switch_filter #(
    parameter int SWITCH_CNT    = 16,
    parameter int FILTER_CYCLES = 100000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [SWITCH_CNT-1:0] switch_raw,
    output logic [SWITCH_CNT-1:0] switch_map
);

    localparam int CNT_W = $clog2(FILTER_CYCLES + 1);

    logic [SWITCH_CNT-1:0] sync_meta;
    logic [SWITCH_CNT-1:0] sync_q;
    logic [SWITCH_CNT-1:0] candidate;  // value currently being timed
    logic [CNT_W-1:0]      stable_cnt;
    logic                  settled;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= switch_raw;
            sync_q    <= sync_meta;
        end
    end

    assign settled = (stable_cnt == CNT_W'(FILTER_CYCLES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            candidate  <= '0;
            stable_cnt <= '0;
        end else if (sync_q != candidate) begin
            candidate  <= sync_q;  // any change restarts the timer
            stable_cnt <= '0;
        end else if (!settled) begin
            stable_cnt <= stable_cnt + CNT_W'(1);
        end
    end

    // publish only a value that has held long enough
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            switch_map <= '0;
        end else if (settled && (sync_q == candidate)) begin
            switch_map <= candidate;
        end
    end

endmodule

`default_nettype wire

// File: keypad/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

// SCAN_DIV should be at least 3 so the synchronized columns
// belong to the current row by the end of its slot
module keypad_scanner #(
    parameter int SCAN_DIV       = 50000,
    parameter int DEBOUNCE_SCANS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [3:0]           key_col,
    output logic [3:0]           key_row,
    output input_pkg::key_code_t key_coord
);
    import input_pkg::*;

    localparam int DIV_W = $clog2(SCAN_DIV + 1);
    localparam int RUN_W = $clog2(DEBOUNCE_SCANS + 1);

    logic [3:0]       col_meta;
    logic [3:0]       col_sync;
    logic [DIV_W-1:0] div_cnt;
    logic             slot_end;
    logic             scan_end;
    logic [3:0]       col_pick;
    logic             row_hit;
    logic             scan_hit;   // a key was already seen in this scan
    logic [7:0]       scan_code;
    logic [7:0]       code_now;
    logic [7:0]       last_code;
    logic [RUN_W-1:0] run_cnt;
    logic [RUN_W-1:0] run_next;
    logic             locked;
    logic             fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_meta <= 4'hF;  // columns idle high
            col_sync <= 4'hF;
        end else begin
            col_meta <= key_col;
            col_sync <= col_meta;
        end
    end

    assign slot_end = (div_cnt == DIV_W'(SCAN_DIV - 1));
    assign scan_end = slot_end && !key_row[3];  // last slot of the scan

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            key_row <= 4'b1110;  // row 0 first
        end else if (slot_end) begin
            div_cnt <= '0;
            key_row <= {key_row[2:0], key_row[3]};
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // lowest pulled column wins when several are low
    always_comb begin
        col_pick = 4'hF;
        if (!col_sync[0]) begin
            col_pick = 4'b1110;
        end else if (!col_sync[1]) begin
            col_pick = 4'b1101;
        end else if (!col_sync[2]) begin
            col_pick = 4'b1011;
        end else if (!col_sync[3]) begin
            col_pick = 4'b0111;
        end
    end

    assign row_hit  = (col_sync != 4'hF);
    assign code_now = scan_hit ? scan_code : (row_hit ? {key_row, col_pick} : 8'h00);

    always_comb begin
        if (code_now != last_code) begin
            run_next = RUN_W'(1);  // new code starts a fresh run
        end else if (run_cnt != RUN_W'(DEBOUNCE_SCANS)) begin
            run_next = run_cnt + RUN_W'(1);
        end else begin
            run_next = run_cnt;  // saturate while held
        end
    end

    assign fire = scan_end && (code_now != 8'h00) && !locked &&
                  (run_next == RUN_W'(DEBOUNCE_SCANS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_hit  <= 1'b0;
            scan_code <= 8'h00;
        end else if (slot_end) begin
            if (scan_end) begin
                scan_hit  <= 1'b0;
                scan_code <= 8'h00;
            end else if (row_hit && !scan_hit) begin
                scan_hit  <= 1'b1;
                scan_code <= {key_row, col_pick};
            end
        end
    end

    // one verdict per full scan
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_code <= 8'h00;
            run_cnt   <= '0;
            locked    <= 1'b0;
        end else if (scan_end) begin
            if (code_now == 8'h00) begin
                last_code <= 8'h00;  // full scan with nothing pressed
                run_cnt   <= '0;
                locked    <= 1'b0;
            end else begin
                last_code <= code_now;
                run_cnt   <= run_next;
                if (fire) begin
                    locked <= 1'b1;  // hold off until release
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_coord <= KEY_NONE;
        end else begin
            key_coord <= fire ? key_code_t'(code_now) : KEY_NONE;
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (key_coord != KEY_NONE) |=> (key_coord == KEY_NONE));

endmodule

`default_nettype wire

// File: common/input_pkg.sv
`default_nettype none

package input_pkg;

    // keypad codes as {row nibble, column nibble}, both active low
    // row bit n low means row n was driven and column bit m low means column m pulled low
    typedef enum logic [7:0] {
        KEY_NONE      = 8'b0000_0000,  // nothing to report
        KEY_ONE       = 8'b1110_1110,
        KEY_TWO       = 8'b1110_1101,
        KEY_THREE     = 8'b1110_1011,
        KEY_PAUSE     = 8'b1110_0111,  // "A" key
        KEY_FOUR      = 8'b1101_1110,
        KEY_FIVE      = 8'b1101_1101,
        KEY_SIX       = 8'b1101_1011,
        KEY_TOGGLE    = 8'b1101_0111,  // "B" key
        KEY_SEVEN     = 8'b1011_1110,
        KEY_EIGHT     = 8'b1011_1101,
        KEY_NINE      = 8'b1011_1011,
        KEY_C         = 8'b1011_0111,
        KEY_BACKSPACE = 8'b0111_1110,  // "*" key
        KEY_ZERO      = 8'b0111_1101,
        KEY_ENTER     = 8'b0111_1011,  // "#" key
        KEY_D         = 8'b0111_0111
    } key_code_t;

    // input unit states
    typedef enum logic [1:0] {
        ST_BLOCK  = 2'b00,  // idle until the cpu asks for input
        ST_SWITCH = 2'b01,  // data comes from the switch bank
        ST_KEYPAD = 2'b10,  // decimal entry on the keypad
        ST_HALT   = 2'b11   // cpu paused
    } input_state_t;

    // longest decimal number accepted from the keypad
    localparam int MAX_DIGITS = 8;

endpackage

`default_nettype wire
